// File: systolic.f
design/systolicPkg.sv
design/fp8Multiplier.sv
design/fp16Adder.sv
design/macPipeline.sv
design/nibbleLink.sv
design/accumulatorBank.sv
design/systolicCell.sv
tests/systolicCell_asserts.sv
tests/systolicCell_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= systolicCell_tb
FILELIST ?= systolic.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Done: no errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJDIR)

// File: tests/systolicCell_tb.sv
`timescale 1ns/10ps

module systolicCell_tb;
    import systolicPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 8;
    localparam int PassFrames = 20;
    localparam int MaxFrames = 64;
    localparam int DrainTimeout = 64;

    logic clk;
    logic rst_n;
    logic [3:0] colIn;
    logic colCtrlIn;
    logic [3:0] rowIn;
    logic rowCtrlIn;
    logic [3:0] colOut;
    logic colCtrlOut;
    logic [3:0] rowOut;
    logic rowCtrlOut;

    // Reference accumulators and expected words per frame
    logic [15:0] accRef [4];
    logic [15:0] expColWord [MaxFrames];
    logic [15:0] expRowWord [MaxFrames];
    logic [3:0] expColCtrl [MaxFrames];
    logic [3:0] expRowCtrl [MaxFrames];

    logic [15:0] colRx;
    logic [15:0] rowRx;
    logic [3:0] colCtrlRx;
    logic [3:0] rowCtrlRx;
    logic running = 1'b0;
    logic timedOut = 1'b0;
    int cycleIdx = 0;
    int nibbleIdx;
    int txCount = 0;
    int rxCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    logic [31:0] rngState;

    systolicCell #(
        .PipeDepth(3)
    ) DUT (
        .clk(clk), .rst_n(rst_n),
        .colIn(colIn), .colCtrlIn(colCtrlIn), .rowIn(rowIn), .rowCtrlIn(rowCtrlIn),
        .colOut(colOut), .colCtrlOut(colCtrlOut), .rowOut(rowOut), .rowCtrlOut(rowCtrlOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic real scalePow2(input real m, input int e);
        real r;
        r = m;
        for (int i = 0; i < e; i++) begin
            r = r * 2.0;
        end
        for (int i = 0; i > e; i--) begin
            r = r / 2.0;
        end
        return r;
    endfunction

    // Exponent 0 reads as zero, exponent 31 as an ordinary exponent
    function automatic real fp8Value(input logic [7:0] v);
        real m;
        if (v[6:2] == 5'd0) begin
            return 0.0;
        end
        m = scalePow2(1.0 + real'(v[1:0]) / 4.0, int'(v[6:2]) - 15);
        return v[7] ? -m : m;
    endfunction

    function automatic real fp16Value(input logic [15:0] v);
        real m;
        if (v[14:10] == 5'd0) begin
            return 0.0;
        end
        m = scalePow2(1.0 + real'(v[9:0]) / 1024.0, int'(v[14:10]) - 15);
        return v[15] ? -m : m;
    endfunction

    // Saturates at exponent 31, flushes underflow to zero
    function automatic logic [15:0] fp16FromReal(input real r);
        real mag;
        int e;
        int man;
        logic s;
        if (r == 0.0) begin
            return 16'h0000;
        end
        s = (r < 0.0);
        mag = s ? -r : r;
        e = 15;
        while (mag >= 2.0) begin
            mag = mag / 2.0;
            e++;
        end
        while (mag < 1.0) begin
            mag = mag * 2.0;
            e--;
        end
        man = int'((mag - 1.0) * 1024.0);
        if (man == 1024) begin
            man = 0;
            e++;
        end
        if (e >= FpExpMax) begin
            return {s, 5'(FpExpMax), 10'd0};
        end
        if (e <= 0) begin
            return 16'h0000;
        end
        return {s, 5'(e), 10'(man)};
    endfunction

    function automatic logic [15:0] macStep(input logic [15:0] acc, input logic [7:0] a,
                                            input logic [7:0] b);
        logic [15:0] prod;
        prod = fp16FromReal(fp8Value(a) * fp8Value(b));
        return fp16FromReal(fp16Value(acc) + fp16Value(prod));
    endfunction

    // Applies the frame to the reference, a MAC frame must be followed by a non-swap frame
    task automatic predictFrame(input logic [15:0] colWord, input logic [3:0] colCtrl,
                                input logic [15:0] rowWord, input logic [3:0] rowCtrl);
        addr_t colAddr;
        addr_t rowAddr;
        colAddr = colCtrl[3:2];
        rowAddr = rowCtrl[3:2];
        expColCtrl[txCount] = colCtrl;
        expRowCtrl[txCount] = rowCtrl;
        expColWord[txCount] = colWord;
        expRowWord[txCount] = rowWord;
        if (colAddr == AddrLoadLo || colAddr == AddrLoadHi) begin
            expColWord[txCount] = accRef[colAddr == AddrLoadLo ? 0 : 2];
            accRef[colAddr == AddrLoadLo ? 0 : 2] = colWord;
        end
        if (rowAddr == AddrLoadLo || rowAddr == AddrLoadHi) begin
            expRowWord[txCount] = accRef[rowAddr == AddrLoadLo ? 1 : 3];
            accRef[rowAddr == AddrLoadLo ? 1 : 3] = rowWord;
        end
        if (colAddr == AddrMac && rowAddr == AddrMac) begin
            // Operand 0 in the upper byte
            accRef[0] = macStep(accRef[0], colWord[15:8], rowWord[15:8]);
            accRef[1] = macStep(accRef[1], colWord[7:0], rowWord[15:8]);
            accRef[2] = macStep(accRef[2], colWord[15:8], rowWord[7:0]);
            accRef[3] = macStep(accRef[3], colWord[7:0], rowWord[7:0]);
        end
    endtask

    // Starts right after the edge that begins phase 0
    task automatic sendFrame(input logic [15:0] colWord, input logic [3:0] colCtrl,
                             input logic [15:0] rowWord, input logic [3:0] rowCtrl);
        predictFrame(colWord, colCtrl, rowWord, rowCtrl);
        for (int k = 0; k < 4; k++) begin
            colIn <= colWord[15 - 4 * k -: 4];
            colCtrlIn <= colCtrl[3 - k];
            rowIn <= rowWord[15 - 4 * k -: 4];
            rowCtrlIn <= rowCtrl[3 - k];
            @(posedge clk);
        end
        txCount++;
    endtask

    task automatic swapAccumulators(input logic [15:0] c0, input logic [15:0] c1,
                                    input logic [15:0] c2, input logic [15:0] c3);
        sendFrame(c0, {AddrLoadLo, 2'b01}, c1, {AddrLoadLo, 2'b10});
        sendFrame(c2, {AddrLoadHi, 2'b11}, c3, {AddrLoadHi, 2'b00});
    endtask

    task automatic compareWord(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Output nibble k of frame n shows in phase k+1 of frame n+1
    always @(negedge clk) begin
        if (running) begin
            if (cycleIdx < 5) begin
                checkCount++;
                assert ({colOut, colCtrlOut, rowOut, rowCtrlOut} === 10'd0) else begin
                    errorCount++;
                    $display("** Error at %0t: outputs expected 000, got %h", $time,
                             {colOut, colCtrlOut, rowOut, rowCtrlOut});
                end
            end else begin
                nibbleIdx = (cycleIdx - 5) % 4;
                colRx[15 - 4 * nibbleIdx -: 4] = colOut;
                rowRx[15 - 4 * nibbleIdx -: 4] = rowOut;
                colCtrlRx[3 - nibbleIdx] = colCtrlOut;
                rowCtrlRx[3 - nibbleIdx] = rowCtrlOut;
                if (nibbleIdx == 3 && rxCount < txCount) begin
                    compareWord("colOut", expColWord[rxCount], colRx);
                    compareWord("rowOut", expRowWord[rxCount], rowRx);
                    compareWord("colCtrlOut", 16'(expColCtrl[rxCount]), 16'(colCtrlRx));
                    compareWord("rowCtrlOut", 16'(expRowCtrl[rxCount]), 16'(rowCtrlRx));
                    rxCount++;
                end
            end
            cycleIdx++;
        end
    end

    initial begin
        logic [15:0] w0;
        logic [15:0] w1;
        int waitCycles;
        rst_n = 1'b0;
        colIn = '0;
        colCtrlIn = 1'b0;
        rowIn = '0;
        rowCtrlIn = 1'b0;
        rngState = 32'h8c62_5a60;
        for (int i = 0; i < 4; i++) begin
            accRef[i] = 16'h0000;
        end
        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
        running = 1'b1;

        // Pass-through with random words and control bits
        for (int n = 0; n < PassFrames; n++) begin
            rngState = xorshift32(rngState);
            w0 = rngState[15:0];
            w1 = rngState[31:16];
            rngState = xorshift32(rngState);
            sendFrame(w0, {AddrPass, rngState[1:0]}, w1, {AddrPass, rngState[3:2]});
        end

        // Random loads, then exact MAC start values push them back out
        rngState = xorshift32(rngState);
        w0 = rngState[15:0];
        w1 = rngState[31:16];
        swapAccumulators(w0, w1, ~w0, ~w1);
        swapAccumulators(16'h3C00, 16'h3800, 16'h4200, 16'hBA00);

        // A0 1.5, A1 2.0, B0 2.0, B1 -1.25
        sendFrame({8'h3E, 8'h40}, {AddrMac, 2'b00}, {8'h40, 8'hBD}, {AddrMac, 2'b11});
        sendFrame(16'h0000, 4'h0, 16'h0000, 4'h0);
        // Small normals let a misread zero operand show in the sum
        swapAccumulators(16'h0400, 16'h8400, 16'h0800, 16'h0C00);

        // Zero operands, then a MAC address on the column link only
        sendFrame(16'h0000, {AddrMac, 2'b01}, {8'h40, 8'h40}, {AddrMac, 2'b10});
        sendFrame({8'h3E, 8'h40}, {AddrMac, 2'b00}, {8'h40, 8'hBD}, {AddrPass, 2'b11});
        sendFrame(16'h0000, 4'h0, 16'h0000, 4'h0);
        swapAccumulators(16'h7B00, 16'h7B00, 16'h7B00, 16'h7B00);

        // Largest operands into large accumulators
        sendFrame(16'h7F7F, {AddrMac, 2'b10}, 16'h7F7F, {AddrMac, 2'b01});
        sendFrame(16'h0000, 4'h0, 16'h0000, 4'h0);
        swapAccumulators(16'h0000, 16'h0000, 16'h0000, 16'h0000);

        colIn <= '0;
        colCtrlIn <= 1'b0;
        rowIn <= '0;
        rowCtrlIn <= 1'b0;
        waitCycles = 0;
        while (rxCount < txCount && waitCycles < DrainTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rxCount < txCount) begin
            timedOut = 1'b1;
            $display("Timeout: only %0d of %0d output frames arrived", rxCount, txCount);
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d, frames: %0d of %0d",
                 checkCount, errorCount, DUT.asserts.failCount, rxCount, txCount);
        if (errorCount == 0 && DUT.asserts.failCount == 0 && !timedOut) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tests/systolicCell_asserts.sv
`timescale 1ns/10ps

module systolicCell_asserts #(
    parameter int PipeDepth = 3
) (
    input logic clk,
    input logic rst_n,
    input systolicPkg::phase_t phase,
    input logic [systolicPkg::NibbleWidth-1:0] colOut,
    input logic colCtrlOut,
    input logic [systolicPkg::NibbleWidth-1:0] rowOut,
    input logic rowCtrlOut
);
    import systolicPkg::*;

    int failCount = 0;

    // Registered outputs clear on the first reset edge
    resetOutputsZero: assert property (@(posedge clk)
        !rst_n |=> (colOut == '0 && !colCtrlOut && rowOut == '0 && !rowCtrlOut))
        else begin
            $error("outputs not zero while reset is held");
            failCount++;
        end

    phaseStep: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (phase == phase_t'($past(phase) + phase_t'(1))))
        else begin
            $error("phase did not advance by one");
            failCount++;
        end

    // Write-back lands on the right phase only with three stages
    pipeDepthFixed: assert property (@(posedge clk) PipeDepth == 3)
        else begin
            $error("PipeDepth differs from 3");
            failCount++;
        end

endmodule

bind systolicCell systolicCell_asserts #(
    .PipeDepth(PipeDepth)
) asserts (
    .clk(clk), .rst_n(rst_n), .phase(phase),
    .colOut(colOut), .colCtrlOut(colCtrlOut),
    .rowOut(rowOut), .rowCtrlOut(rowCtrlOut)
);

// File: design/systolicCell.sv
`timescale 1ns/10ps

module systolicCell #(
    parameter int PipeDepth = 3
) (
    input logic clk,
    input logic rst_n,
    input logic [systolicPkg::NibbleWidth-1:0] colIn,
    input logic colCtrlIn,
    input logic [systolicPkg::NibbleWidth-1:0] rowIn,
    input logic rowCtrlIn,
    output logic [systolicPkg::NibbleWidth-1:0] colOut,
    output logic colCtrlOut,
    output logic [systolicPkg::NibbleWidth-1:0] rowOut,
    output logic rowCtrlOut
);
    import systolicPkg::*;

    phase_t phase;
    linkWord_u colWordIn, colWordOut, rowWordIn, rowWordOut;
    addr_t colAddrIn, colAddrOut, rowAddrIn, rowAddrOut;
    linkWord_u acc0, acc1, acc2, acc3;
    fp16_t result;
    logic resultValid;

    // Frame phase, 0 in the first cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + phase_t'(1);
        end
    end

    // Column link swaps C0 and C2
    nibbleLink colLink (
        .clk(clk), .rst_n(rst_n), .phase(phase),
        .dataIn(colIn), .ctrlIn(colCtrlIn), .accLo(acc0), .accHi(acc2),
        .wordIn(colWordIn), .addrIn(colAddrIn), .wordOut(colWordOut), .addrOut(colAddrOut),
        .dataOut(colOut), .ctrlOut(colCtrlOut)
    );

    // Row link swaps C1 and C3
    nibbleLink rowLink (
        .clk(clk), .rst_n(rst_n), .phase(phase),
        .dataIn(rowIn), .ctrlIn(rowCtrlIn), .accLo(acc1), .accHi(acc3),
        .wordIn(rowWordIn), .addrIn(rowAddrIn), .wordOut(rowWordOut), .addrOut(rowAddrOut),
        .dataOut(rowOut), .ctrlOut(rowCtrlOut)
    );

    accumulatorBank bank (
        .clk(clk), .rst_n(rst_n), .phase(phase),
        .colWord(colWordIn), .rowWord(rowWordIn), .colAddr(colAddrIn), .rowAddr(rowAddrIn),
        .result(result), .resultValid(resultValid),
        .acc0(acc0), .acc1(acc1), .acc2(acc2), .acc3(acc3)
    );

    macPipeline #(
        .PipeDepth(PipeDepth)
    ) mac (
        .clk(clk), .rst_n(rst_n), .phase(phase),
        .colWordIn(colWordIn), .colWordOut(colWordOut),
        .rowWordIn(rowWordIn), .rowWordOut(rowWordOut),
        .colAddrIn(colAddrIn), .colAddrOut(colAddrOut),
        .rowAddrIn(rowAddrIn), .rowAddrOut(rowAddrOut),
        .acc0(acc0), .acc1(acc1), .acc2(acc2), .acc3(acc3),
        .result(result), .resultValid(resultValid)
    );

endmodule

// File: design/accumulatorBank.sv
`timescale 1ns/10ps

module accumulatorBank (
    input logic clk,
    input logic rst_n,
    input systolicPkg::phase_t phase,
    input systolicPkg::linkWord_u colWord,
    input systolicPkg::linkWord_u rowWord,
    input systolicPkg::addr_t colAddr,
    input systolicPkg::addr_t rowAddr,
    input systolicPkg::fp16_t result,
    input logic resultValid,
    output systolicPkg::linkWord_u acc0,
    output systolicPkg::linkWord_u acc1,
    output systolicPkg::linkWord_u acc2,
    output systolicPkg::linkWord_u acc3
);
    import systolicPkg::*;

    linkWord_u accReg [FrameLen];
    phase_t wbIdx;
    logic lastPhase;

    // Issued in phase p, written at the end of phase p+3 into accumulator p+2
    assign wbIdx = phase - phase_t'(1);
    assign lastPhase = (phase == phase_t'(FrameLen - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < FrameLen; i++) begin
                accReg[i] <= '0;
            end
        end else begin
            if (resultValid) begin
                accReg[wbIdx].acc <= result;
            end
            // Loads come last and so override the C2 write-back
            if (lastPhase) begin
                case (colAddr)
                    AddrLoadLo: accReg[0] <= colWord;
                    AddrLoadHi: accReg[2] <= colWord;
                    default: ;
                endcase
                case (rowAddr)
                    AddrLoadLo: accReg[1] <= rowWord;
                    AddrLoadHi: accReg[3] <= rowWord;
                    default: ;
                endcase
            end
        end
    end

    assign acc0 = accReg[0];
    assign acc1 = accReg[1];
    assign acc2 = accReg[2];
    assign acc3 = accReg[3];

endmodule

// File: design/nibbleLink.sv
`timescale 1ns/10ps

module nibbleLink (
    input logic clk,
    input logic rst_n,
    input systolicPkg::phase_t phase,
    input logic [systolicPkg::NibbleWidth-1:0] dataIn,
    input logic ctrlIn,
    input systolicPkg::linkWord_u accLo,
    input systolicPkg::linkWord_u accHi,
    output systolicPkg::linkWord_u wordIn,
    output systolicPkg::addr_t addrIn,
    output systolicPkg::linkWord_u wordOut,
    output systolicPkg::addr_t addrOut,
    output logic [systolicPkg::NibbleWidth-1:0] dataOut,
    output logic ctrlOut
);
    import systolicPkg::*;

    logic [WordWidth-NibbleWidth-1:0] inBuf;
    logic [FrameLen-2:0] ctrlInBuf;
    logic [FrameLen-1:0] ctrlInWord;
    logic [FrameLen-1:0] ctrlOutBuf;
    logic lastPhase;

    assign lastPhase = (phase == phase_t'(FrameLen - 1));

    // Full words valid only in the last phase
    assign wordIn = {inBuf, dataIn};
    assign ctrlInWord = {ctrlInBuf, ctrlIn};
    assign addrIn = ctrlInWord[FrameLen-1 -: $bits(addr_t)];
    assign addrOut = ctrlOutBuf[FrameLen-1 -: $bits(addr_t)];

    // Most significant nibble arrives first
    always_ff @(posedge clk) begin
        if (!lastPhase) begin
            inBuf[WordWidth - NibbleWidth - 1 - NibbleWidth * int'(phase) -: NibbleWidth] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrlInBuf <= '0;
        end else if (!lastPhase) begin
            ctrlInBuf[FrameLen - 2 - int'(phase)] <= ctrlIn;
        end
    end

    // Outgoing buffer and serializer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wordOut <= '0;
            ctrlOutBuf <= '0;
            dataOut <= '0;
            ctrlOut <= 1'b0;
        end else begin
            dataOut <= wordOut[WordWidth - 1 - NibbleWidth * int'(phase) -: NibbleWidth];
            ctrlOut <= ctrlOutBuf[FrameLen - 1 - int'(phase)];
            if (lastPhase) begin
                ctrlOutBuf <= ctrlInWord;
                // Swap sends the old accumulator onward
                unique case (addrIn)
                    AddrPass, AddrMac: wordOut <= wordIn;
                    AddrLoadLo: wordOut <= accLo;
                    AddrLoadHi: wordOut <= accHi;
                endcase
            end
        end
    end

endmodule

// File: design/macPipeline.sv
`timescale 1ns/10ps

module macPipeline #(
    parameter int PipeDepth = 3
) (
    input logic clk,
    input logic rst_n,
    input systolicPkg::phase_t phase,
    input systolicPkg::linkWord_u colWordIn,
    input systolicPkg::linkWord_u colWordOut,
    input systolicPkg::linkWord_u rowWordIn,
    input systolicPkg::linkWord_u rowWordOut,
    input systolicPkg::addr_t colAddrIn,
    input systolicPkg::addr_t colAddrOut,
    input systolicPkg::addr_t rowAddrIn,
    input systolicPkg::addr_t rowAddrOut,
    input systolicPkg::linkWord_u acc0,
    input systolicPkg::linkWord_u acc1,
    input systolicPkg::linkWord_u acc2,
    input systolicPkg::linkWord_u acc3,
    output systolicPkg::fp16_t result,
    output logic resultValid
);
    import systolicPkg::*;

    fp8_t opA;
    fp8_t opB;
    linkWord_u accSel;
    logic issueValid;
    fp16_t product;
    fp16_t prodQ;
    fp16_t accQ;
    fp16_t sum;
    fp16_t sumPipe [PipeDepth-1];
    logic [PipeDepth-1:0] validPipe;

    // Phases 2 and 3 read the incoming words, phases 0 and 1 the outgoing buffers
    always_comb begin
        unique case (phase)
            2'd2: begin
                opA = colWordIn.op.hi;
                opB = rowWordIn.op.hi;
                accSel = acc0;
            end
            2'd3: begin
                opA = colWordIn.op.lo;
                opB = rowWordIn.op.hi;
                accSel = acc1;
            end
            2'd0: begin
                opA = colWordOut.op.hi;
                opB = rowWordOut.op.lo;
                accSel = acc2;
            end
            2'd1: begin
                opA = colWordOut.op.lo;
                opB = rowWordOut.op.lo;
                accSel = acc3;
            end
        endcase
    end

    assign issueValid = phase[1] ? (colAddrIn == AddrMac && rowAddrIn == AddrMac)
                                 : (colAddrOut == AddrMac && rowAddrOut == AddrMac);

    fp8Multiplier mult (.a(opA), .b(opB), .product(product));

    fp16Adder add (.x(prodQ), .y(accQ), .sum(sum));

    // Product stage, sum stage, then hold stages
    always_ff @(posedge clk) begin
        prodQ <= product;
        accQ <= accSel.acc;
        sumPipe[0] <= sum;
        for (int i = 1; i < PipeDepth - 1; i++) begin
            sumPipe[i] <= sumPipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[PipeDepth-2:0], issueValid};
        end
    end

    assign result = sumPipe[PipeDepth-2];
    assign resultValid = validPipe[PipeDepth-1];

endmodule

// File: design/fp16Adder.sv
`timescale 1ns/10ps

module fp16Adder (
    input systolicPkg::fp16_t x,
    input systolicPkg::fp16_t y,
    output systolicPkg::fp16_t sum
);
    import systolicPkg::*;

    fp16_t bigOp;
    fp16_t smallOp;
    logic [13:0] bigSig;
    logic [13:0] smallSig;
    logic [4:0] shiftAmt;
    logic [28:0] shiftWide;
    logic [13:0] alignedSig;
    logic [14:0] rawSum;
    logic [13:0] normSig;
    logic roundUp;
    logic [11:0] roundSig;
    logic [9:0] manRes;
    int lead;
    int expNorm;
    int expRes;

    always_comb begin
        // Larger magnitude first
        if ({x.exp, x.man} >= {y.exp, y.man}) begin
            bigOp = x;
            smallOp = y;
        end else begin
            bigOp = y;
            smallOp = x;
        end

        // Hidden bit, 10 fraction bits, guard, round, sticky
        bigSig = (bigOp.exp == '0) ? '0 : {1'b1, bigOp.man, 3'b000};
        smallSig = (smallOp.exp == '0) ? '0 : {1'b1, smallOp.man, 3'b000};

        // Beyond 15 places only the sticky bit is left
        shiftAmt = bigOp.exp - smallOp.exp;
        if (shiftAmt > 5'd15) begin
            shiftAmt = 5'd15;
        end
        shiftWide = {smallSig, 15'b0} >> shiftAmt;
        alignedSig = {shiftWide[28:16], |shiftWide[15:0]};

        if (bigOp.sign != smallOp.sign) begin
            rawSum = {1'b0, bigSig} - {1'b0, alignedSig};
        end else begin
            rawSum = {1'b0, bigSig} + {1'b0, alignedSig};
        end

        // Leading-one search
        lead = 0;
        for (int i = 0; i < 15; i++) begin
            if (rawSum[i]) begin
                lead = i;
            end
        end

        if (lead == 14) begin
            // Carry out of the add, shift right and keep the sticky
            normSig = {rawSum[14:2], |rawSum[1:0]};
            expNorm = int'(bigOp.exp) + 1;
        end else begin
            normSig = rawSum[13:0] << (13 - lead);
            expNorm = int'(bigOp.exp) - (13 - lead);
        end

        // Round to nearest even
        roundUp = normSig[2] & (normSig[1] | normSig[0] | normSig[3]);
        roundSig = {1'b0, normSig[13:3]} + 12'(roundUp);
        if (roundSig[11]) begin
            expRes = expNorm + 1;
            manRes = roundSig[10:1];
        end else begin
            expRes = expNorm;
            manRes = roundSig[9:0];
        end

        // Exact cancellation and underflow give +0
        sum = '0;
        if (rawSum != '0 && expRes > 0) begin
            sum.sign = bigOp.sign;
            if (expRes >= FpExpMax) begin
                sum.exp = 5'(FpExpMax);
            end else begin
                sum.exp = 5'(expRes);
                sum.man = manRes;
            end
        end
    end

endmodule

// File: design/fp8Multiplier.sv
`timescale 1ns/10ps

module fp8Multiplier (
    input systolicPkg::fp8_t a,
    input systolicPkg::fp8_t b,
    output systolicPkg::fp16_t product
);
    import systolicPkg::*;

    logic [5:0] sigProd;
    logic [9:0] frac;
    int expSum;

    always_comb begin
        // 1.xx times 1.xx lies in [1, 4)
        sigProd = {1'b1, a.man} * {1'b1, b.man};

        // The exact product fits the 10-bit fraction
        if (sigProd[5]) begin
            frac = {sigProd[4:0], 5'b0};
        end else begin
            frac = {sigProd[3:0], 6'b0};
        end

        // Remove one bias, add the normalization shift
        expSum = int'(a.exp) + int'(b.exp) - 15 + int'(sigProd[5]);

        product.sign = a.sign ^ b.sign;
        if (a.exp == '0 || b.exp == '0 || expSum <= 0) begin
            // Zero operand or underflow
            product.exp = '0;
            product.man = '0;
        end else if (expSum >= FpExpMax) begin
            product.exp = 5'(FpExpMax);
            product.man = '0;
        end else begin
            product.exp = 5'(expSum);
            product.man = frac;
        end
    end

endmodule

// File: design/systolicPkg.sv
package systolicPkg;

    localparam int NibbleWidth = 4;
    localparam int FrameLen = 4;
    localparam int WordWidth = 16;
    localparam int FpExpMax = 31;

    typedef logic [1:0] phase_t;
    typedef logic [1:0] addr_t;

    // Top two bits of the 4-bit control word
    localparam addr_t AddrPass = 2'd0;
    localparam addr_t AddrMac = 2'd1;
    localparam addr_t AddrLoadLo = 2'd2;
    localparam addr_t AddrLoadHi = 2'd3;

    // E5M2 operand
    typedef struct packed {
        logic sign;
        logic [4:0] exp;
        logic [1:0] man;
    } fp8_t;

    typedef struct packed {
        logic sign;
        logic [4:0] exp;
        logic [9:0] man;
    } fp16_t;

    // Operand pair for MAC frames, accumulator value for load frames
    typedef union packed {
        struct packed {
            fp8_t hi;
            fp8_t lo;
        } op;
        fp16_t acc;
    } linkWord_u;

endpackage
